// File: include/spram_macros.svh
// Geometry of the shared memory subsystem.
// Word address width must exceed the macro address width (at least two banks).
// Data width must be a whole number of bytes; port count must be two or more.
`ifndef SPRAM_MACROS_SVH
`define SPRAM_MACROS_SVH

// data word and word address
`define SPRAM_DW 32
`define SPRAM_AW 10

// hardened macro of 64 bits x 256 words
`define SPRAM_MACRO_W 64
`define SPRAM_MACRO_AW 8

// AXI4-Lite ports sharing the RAM
`define SPRAM_PORTS 2

`endif

// File: source/spram_pkg.sv
// Types shared by the AXI ports, the arbiter and the top level.
// Request field widths come from spram_macros.svh.
`include "spram_macros.svh"

package spram_pkg;

    // AXI response code of which only OKAY is returned
    typedef enum logic [1:0] {
        AXI_OKAY   = 2'b00,
        AXI_EXOKAY = 2'b01,
        AXI_SLVERR = 2'b10,
        AXI_DECERR = 2'b11
    } axi_resp_t;

    // one memory access from port to arbiter
    typedef struct packed {
        logic                 we;     // 1 = write
        logic [`SPRAM_AW-1:0] addr;   // word address
        logic [`SPRAM_DW-1:0] wdata;
        logic [`SPRAM_DW-1:0] wmask;  // per bit mask built from wstrb
    } mem_req_t;

endpackage

// File: source/sram_macro_model.sv
// Behavioral stand-in for the 64x256 single-port SRAM macro.
// Simulation only; no power, control or test pins.
// Read data appears one cycle after ce with we low and holds until the next read.
`timescale 1ns/1ps
`include "spram_macros.svh"

module sram_macro_model (
    input  logic                       clk,
    input  logic                       ce,     // chip enable
    input  logic                       we,     // write enable
    input  logic [`SPRAM_MACRO_AW-1:0] addr,
    input  logic [`SPRAM_MACRO_W-1:0]  din,
    input  logic [`SPRAM_MACRO_W-1:0]  wmask,  // per bit
    output logic [`SPRAM_MACRO_W-1:0]  dout
);

    localparam int DEPTH = 1 << `SPRAM_MACRO_AW;

    logic [`SPRAM_MACRO_W-1:0] mem [DEPTH];  // cell array

    always_ff @(posedge clk) begin
        if (ce) begin
            if (we) begin
                mem[addr] <= (mem[addr] & ~wmask) | (din & wmask);  // masked bits only
            end else begin
                dout <= mem[addr];  // registered read
            end
        end
    end

endmodule

// File: source/spram_tiled.sv
// Single-port RAM built by tiling the 64x256 macro.
// Upper address bits pick a bank, width is covered by slices of 64 bits.
// Read data is valid one cycle after ce with we low; writes land on the ce/we edge.
// Assumes SPRAM_AW > SPRAM_MACRO_AW.
`timescale 1ns/1ps
`include "spram_macros.svh"

module spram_tiled (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ce,
    input  logic                 we,
    input  logic [`SPRAM_AW-1:0] addr,   // word address
    input  logic [`SPRAM_DW-1:0] din,
    input  logic [`SPRAM_DW-1:0] wmask,  // per bit write mask
    output logic [`SPRAM_DW-1:0] dout
);

    localparam int BSW    = `SPRAM_AW - `SPRAM_MACRO_AW;  // bank select bits
    localparam int BANKS  = 1 << BSW;
    localparam int SLICES = (`SPRAM_DW + `SPRAM_MACRO_W - 1) / `SPRAM_MACRO_W;
    localparam int PADW   = SLICES * `SPRAM_MACRO_W;      // width rounded to macros

    logic [BSW-1:0]  bank_sel;
    logic [BSW-1:0]  rd_bank_q;          // bank of last read
    logic [PADW-1:0] din_pad;
    logic [PADW-1:0] wmask_pad;
    logic [PADW-1:0] bank_dout [BANKS];  // zero unless bank was read
    logic [PADW-1:0] merged;

    assign bank_sel  = addr[`SPRAM_AW-1:`SPRAM_MACRO_AW];
    assign din_pad   = PADW'(din);    // upper pad bits zero
    assign wmask_pad = PADW'(wmask);  // pad bits never written

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_bank_q <= '0;
        end else if (ce && !we) begin
            rd_bank_q <= bank_sel;  // lines up with macro read latency
        end
    end

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        logic            bank_ce;
        logic            bank_we;
        logic [PADW-1:0] raw;

        assign bank_ce = ce && (bank_sel == BSW'(b));
        assign bank_we = we && (bank_sel == BSW'(b));

        for (genvar s = 0; s < SLICES; s++) begin : g_slice
            sram_macro_model u_macro (
                .clk   (clk),
                .ce    (bank_ce),
                .we    (bank_we),
                .addr  (addr[`SPRAM_MACRO_AW-1:0]),
                .din   (din_pad[s*`SPRAM_MACRO_W +: `SPRAM_MACRO_W]),
                .wmask (wmask_pad[s*`SPRAM_MACRO_W +: `SPRAM_MACRO_W]),
                .dout  (raw[s*`SPRAM_MACRO_W +: `SPRAM_MACRO_W])
            );
        end

        // macro output holds stale data, so mask off unselected banks
        assign bank_dout[b] = (rd_bank_q == BSW'(b)) ? raw : '0;
    end

    // OR merge across banks
    always_comb begin
        merged = '0;
        for (int b = 0; b < BANKS; b++) begin
            merged = merged | bank_dout[b];
        end
    end

    assign dout = merged[`SPRAM_DW-1:0];  // drop pad bits

endmodule

// File: source/mem_arbiter.sv
// Round-robin arbiter in front of the shared RAM.
// Grant is combinational in the request cycle; a new request can be taken every cycle.
// Read data returns to the issuing port one cycle after the read is granted.
`timescale 1ns/1ps
`include "spram_macros.svh"

module mem_arbiter
    import spram_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [`SPRAM_PORTS-1:0]     req_valid,
    input  mem_req_t [`SPRAM_PORTS-1:0] req,
    output logic [`SPRAM_PORTS-1:0]     req_ready,  // one-hot grant
    output logic [`SPRAM_PORTS-1:0]     rsp_valid,  // read data strobe per port
    output logic [`SPRAM_DW-1:0]        rsp_rdata,  // shared by all ports
    output logic                        mem_ce,
    output logic                        mem_we,
    output logic [`SPRAM_AW-1:0]        mem_addr,
    output logic [`SPRAM_DW-1:0]        mem_din,
    output logic [`SPRAM_DW-1:0]        mem_wmask,
    input  logic [`SPRAM_DW-1:0]        mem_dout
);

    localparam int PW = $clog2(`SPRAM_PORTS);

    logic [`SPRAM_PORTS-1:0] grant;
    logic [PW-1:0]           grant_idx;
    logic [PW-1:0]           last_q;     // last granted port
    logic                    rd_pend_q;  // read issued last cycle
    logic [PW-1:0]           rd_port_q;  // who issued it

    // search starts one past the last winner
    always_comb begin
        int idx;
        grant     = '0;
        grant_idx = last_q;
        for (int i = 1; i <= `SPRAM_PORTS; i++) begin
            idx = (int'(last_q) + i) % `SPRAM_PORTS;
            if (grant == '0 && req_valid[idx]) begin
                grant[idx] = 1'b1;
                grant_idx  = PW'(idx);
            end
        end
    end

    assign req_ready = grant;
    assign mem_ce    = |grant;
    assign mem_we    = req[grant_idx].we;
    assign mem_addr  = req[grant_idx].addr;
    assign mem_din   = req[grant_idx].wdata;
    assign mem_wmask = req[grant_idx].wmask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_q    <= PW'(`SPRAM_PORTS - 1);  // port 0 first after reset
            rd_pend_q <= 1'b0;
            rd_port_q <= '0;
        end else begin
            rd_pend_q <= mem_ce && !mem_we;
            if (mem_ce) begin
                last_q    <= grant_idx;
                rd_port_q <= grant_idx;
            end
        end
    end

    always_comb begin
        for (int p = 0; p < `SPRAM_PORTS; p++) begin
            rsp_valid[p] = rd_pend_q && (rd_port_q == PW'(p));
        end
    end

    assign rsp_rdata = mem_dout;  // RAM output is already registered

endmodule

// File: source/axil_mem_port.sv
// AXI4-Lite slave turning channel traffic into single memory requests.
// One transaction at a time; every response is OKAY, addresses are not range checked.
// AW and W may arrive in either order. AR loses a tie against a pending write.
// Byte address low bits are ignored (word aligned accesses only).
`timescale 1ns/1ps
`include "spram_macros.svh"

module axil_mem_port
    import spram_pkg::*;
#(
    localparam int BW  = `SPRAM_DW / 8,             // strobe lanes
    localparam int ABW = `SPRAM_AW + $clog2(BW)     // byte address width
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [ABW-1:0]       awaddr,
    input  logic                 wvalid,
    output logic                 wready,
    input  logic [`SPRAM_DW-1:0] wdata,
    input  logic [BW-1:0]        wstrb,
    output logic                 bvalid,
    input  logic                 bready,
    output axi_resp_t            bresp,
    input  logic                 arvalid,
    output logic                 arready,
    input  logic [ABW-1:0]       araddr,
    output logic                 rvalid,
    input  logic                 rready,
    output logic [`SPRAM_DW-1:0] rdata,
    output axi_resp_t            rresp,
    output logic                 req_valid,
    output mem_req_t             req,
    input  logic                 req_ready,
    input  logic                 rsp_valid,
    input  logic [`SPRAM_DW-1:0] rsp_rdata
);

    typedef enum logic [2:0] {
        ST_IDLE,   // accepting AW/W/AR
        ST_REQ,    // request toward arbiter
        ST_RWAIT,  // read granted, data next
        ST_BRESP,
        ST_RRESP   // read data held for rready
    } state_t;

    state_t               state_q;
    logic                 aw_done_q;
    logic                 w_done_q;
    logic [ABW-1:0]       awaddr_q;
    logic [`SPRAM_DW-1:0] wdata_q;
    logic [BW-1:0]        wstrb_q;
    logic [`SPRAM_DW-1:0] rdata_q;
    mem_req_t             req_q;
    logic                 idle;
    logic                 aw_hs;
    logic                 w_hs;
    logic                 ar_hs;
    logic                 wr_go;    // both write halves present
    logic [ABW-1:0]       wr_addr;
    logic [`SPRAM_DW-1:0] wr_data;
    logic [BW-1:0]        wr_strb;
    logic [`SPRAM_DW-1:0] wr_mask;

    assign idle    = state_q == ST_IDLE;
    assign awready = idle && !aw_done_q;
    assign wready  = idle && !w_done_q;
    assign arready = idle && !aw_done_q && !awvalid;  // write wins a tie

    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign ar_hs = arvalid && arready;
    assign wr_go = idle && (aw_done_q || aw_hs) && (w_done_q || w_hs);

    // held copy once taken, else the live channel
    assign wr_addr = aw_done_q ? awaddr_q : awaddr;
    assign wr_data = w_done_q ? wdata_q : wdata;
    assign wr_strb = w_done_q ? wstrb_q : wstrb;

    always_comb begin
        for (int i = 0; i < BW; i++) begin
            wr_mask[i*8 +: 8] = {8{wr_strb[i]}};  // byte strobe to bit mask
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q   <= ST_IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (wr_go) begin
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                        state_q   <= ST_REQ;
                    end else begin
                        aw_done_q <= aw_done_q || aw_hs;
                        w_done_q  <= w_done_q || w_hs;
                        if (ar_hs) begin
                            state_q <= ST_REQ;
                        end
                    end
                end
                ST_REQ: begin
                    if (req_ready) begin
                        state_q <= req_q.we ? ST_BRESP : ST_RWAIT;
                    end
                end
                ST_RWAIT: begin
                    if (rsp_valid) begin
                        state_q <= rready ? ST_IDLE : ST_RRESP;  // no wait if taken at once
                    end
                end
                ST_BRESP: begin
                    if (bready) begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_RRESP: begin
                    if (rready) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            awaddr_q <= awaddr;
        end
        if (w_hs) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
        if (wr_go) begin
            req_q <= '{we: 1'b1, addr: wr_addr[ABW-1 -: `SPRAM_AW],
                       wdata: wr_data, wmask: wr_mask};
        end else if (ar_hs) begin
            req_q <= '{we: 1'b0, addr: araddr[ABW-1 -: `SPRAM_AW], wdata: '0, wmask: '0};
        end
        if (state_q == ST_RWAIT && rsp_valid) begin
            rdata_q <= rsp_rdata;  // kept for a stalled rready
        end
    end

    assign req_valid = state_q == ST_REQ;
    assign req       = req_q;
    assign bvalid    = state_q == ST_BRESP;
    assign bresp     = AXI_OKAY;
    assign rvalid    = (state_q == ST_RWAIT && rsp_valid) || state_q == ST_RRESP;
    assign rdata     = (state_q == ST_RRESP) ? rdata_q : rsp_rdata;
    assign rresp     = AXI_OKAY;

endmodule

// File: source/spram_subsystem_top.sv
// Shared SRAM with two AXI4-Lite slave ports (s0_, s1_).
// Byte addresses, 32-bit data, 4 KiB total; see spram_macros.svh for geometry.
// Access latency depends on arbitration against the other port.
`timescale 1ns/1ps
`include "spram_macros.svh"

module spram_subsystem_top
    import spram_pkg::*;
#(
    localparam int BW  = `SPRAM_DW / 8,
    localparam int ABW = `SPRAM_AW + $clog2(BW)
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 s0_awvalid,
    output logic                 s0_awready,
    input  logic [ABW-1:0]       s0_awaddr,
    input  logic                 s0_wvalid,
    output logic                 s0_wready,
    input  logic [`SPRAM_DW-1:0] s0_wdata,
    input  logic [BW-1:0]        s0_wstrb,
    output logic                 s0_bvalid,
    input  logic                 s0_bready,
    output axi_resp_t            s0_bresp,
    input  logic                 s0_arvalid,
    output logic                 s0_arready,
    input  logic [ABW-1:0]       s0_araddr,
    output logic                 s0_rvalid,
    input  logic                 s0_rready,
    output logic [`SPRAM_DW-1:0] s0_rdata,
    output axi_resp_t            s0_rresp,
    input  logic                 s1_awvalid,
    output logic                 s1_awready,
    input  logic [ABW-1:0]       s1_awaddr,
    input  logic                 s1_wvalid,
    output logic                 s1_wready,
    input  logic [`SPRAM_DW-1:0] s1_wdata,
    input  logic [BW-1:0]        s1_wstrb,
    output logic                 s1_bvalid,
    input  logic                 s1_bready,
    output axi_resp_t            s1_bresp,
    input  logic                 s1_arvalid,
    output logic                 s1_arready,
    input  logic [ABW-1:0]       s1_araddr,
    output logic                 s1_rvalid,
    input  logic                 s1_rready,
    output logic [`SPRAM_DW-1:0] s1_rdata,
    output axi_resp_t            s1_rresp
);

    logic [`SPRAM_PORTS-1:0]     req_valid;
    logic [`SPRAM_PORTS-1:0]     req_ready;
    logic [`SPRAM_PORTS-1:0]     rsp_valid;
    mem_req_t [`SPRAM_PORTS-1:0] req;
    logic [`SPRAM_DW-1:0]        rsp_rdata;  // broadcast to both ports
    logic                        mem_ce;
    logic                        mem_we;
    logic [`SPRAM_AW-1:0]        mem_addr;
    logic [`SPRAM_DW-1:0]        mem_din;
    logic [`SPRAM_DW-1:0]        mem_wmask;
    logic [`SPRAM_DW-1:0]        mem_dout;

    axil_mem_port u_port0 (
        .clk(clk), .rst_n(rst_n),
        .awvalid(s0_awvalid), .awready(s0_awready), .awaddr(s0_awaddr),
        .wvalid(s0_wvalid), .wready(s0_wready), .wdata(s0_wdata), .wstrb(s0_wstrb),
        .bvalid(s0_bvalid), .bready(s0_bready), .bresp(s0_bresp),
        .arvalid(s0_arvalid), .arready(s0_arready), .araddr(s0_araddr),
        .rvalid(s0_rvalid), .rready(s0_rready), .rdata(s0_rdata), .rresp(s0_rresp),
        .req_valid(req_valid[0]), .req(req[0]), .req_ready(req_ready[0]),
        .rsp_valid(rsp_valid[0]), .rsp_rdata(rsp_rdata)
    );

    axil_mem_port u_port1 (
        .clk(clk), .rst_n(rst_n),
        .awvalid(s1_awvalid), .awready(s1_awready), .awaddr(s1_awaddr),
        .wvalid(s1_wvalid), .wready(s1_wready), .wdata(s1_wdata), .wstrb(s1_wstrb),
        .bvalid(s1_bvalid), .bready(s1_bready), .bresp(s1_bresp),
        .arvalid(s1_arvalid), .arready(s1_arready), .araddr(s1_araddr),
        .rvalid(s1_rvalid), .rready(s1_rready), .rdata(s1_rdata), .rresp(s1_rresp),
        .req_valid(req_valid[1]), .req(req[1]), .req_ready(req_ready[1]),
        .rsp_valid(rsp_valid[1]), .rsp_rdata(rsp_rdata)
    );

    mem_arbiter u_arb (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata),
        .mem_ce(mem_ce), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_din(mem_din), .mem_wmask(mem_wmask), .mem_dout(mem_dout)
    );

    spram_tiled u_ram (
        .clk(clk), .rst_n(rst_n),
        .ce(mem_ce), .we(mem_we), .addr(mem_addr),
        .din(mem_din), .wmask(mem_wmask), .dout(mem_dout)
    );

endmodule

// File: verification/spram_assertions.sv
// Concurrent checks bound into every AXI port and into the arbiter.
// valid/ready are packed, one bit per channel; checks idle while rst_n is low.
// In a port the read-return checks use bit 0 for the port's own rsp_valid.
`timescale 1ns/1ps
`include "spram_macros.svh"

module spram_assertions #(
    parameter int N = 2
) (
    input logic         clk,
    input logic         rst_n,
    input logic [N-1:0] valid,
    input logic [N-1:0] ready,
    input logic         rd_issue,   // read granted this cycle
    input logic [N-1:0] rd_grant,   // which port got it
    input logic [N-1:0] rsp_valid
);

    for (genvar i = 0; i < N; i++) begin : g_hold
        a_valid_hold: assert property (@(posedge clk) disable iff (!rst_n)
            valid[i] && !ready[i] |=> valid[i])  // no retraction before handshake
            else $error("valid bit %0d dropped before its handshake", i);
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(valid & ready))
        else $error("more than one handshake in a single cycle");

    a_rsp_after_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_issue |=> rsp_valid == $past(rd_grant))  // exactly one cycle later
        else $error("rsp_valid did not follow the granted read");

    a_no_stray_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        !rd_issue |=> rsp_valid == '0)
        else $error("rsp_valid without a read in the previous cycle");

endmodule

// response channels and the request toward the arbiter
bind axil_mem_port spram_assertions #(.N(3)) u_port_chk (
    .clk(clk), .rst_n(rst_n),
    .valid({bvalid, rvalid, req_valid}), .ready({bready, rready, req_ready}),
    .rd_issue(req_valid && req_ready && !req.we), .rd_grant(3'b001),
    .rsp_valid({2'b00, rsp_valid})
);

bind mem_arbiter spram_assertions #(.N(`SPRAM_PORTS)) u_arb_chk (
    .clk(clk), .rst_n(rst_n), .valid(req_valid), .ready(req_ready),
    .rd_issue(mem_ce && !mem_we), .rd_grant(req_ready), .rsp_valid(rsp_valid)
);

// File: verification/tb_spram_subsystem.sv
// Testbench for the two-port shared SRAM; stimulus from verification/spram_input.txt.
// Run from the project root. Lines marked par run on both ports at once and must
// touch different words. Only fully written words may be partially overwritten.
`timescale 1ns/1ps
`include "spram_macros.svh"

module tb_spram_subsystem
    import spram_pkg::*;
;

    localparam int BW   = `SPRAM_DW / 8;
    localparam int ABW  = `SPRAM_AW + $clog2(BW);
    localparam int NCOL = 7;    // tokens per stimulus line
    localparam int MAXL = 64;
    localparam int TMO  = 200;  // cycles per wait

    logic                 clk;
    logic                 rst_n;
    logic [1:0]           awvalid;  // index = port
    logic [1:0]           wvalid;
    logic [1:0]           bready;
    logic [1:0]           arvalid;
    logic [1:0]           rready;
    logic [1:0]           awready;
    logic [1:0]           wready;
    logic [1:0]           bvalid;
    logic [1:0]           arready;
    logic [1:0]           rvalid;
    logic [ABW-1:0]       awaddr [2];
    logic [ABW-1:0]       araddr [2];
    logic [`SPRAM_DW-1:0] wdata [2];
    logic [BW-1:0]        wstrb [2];
    logic [`SPRAM_DW-1:0] rdata [2];
    axi_resp_t            bresp [2];
    axi_resp_t            rresp [2];
    logic [31:0]          stim [NCOL*MAXL];
    logic [`SPRAM_DW-1:0] ref_mem [1 << `SPRAM_AW];  // byte-masked reference
    integer               seed;
    int                   err_count;

    spram_subsystem_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .s0_awvalid(awvalid[0]), .s0_awready(awready[0]), .s0_awaddr(awaddr[0]),
        .s0_wvalid(wvalid[0]), .s0_wready(wready[0]), .s0_wdata(wdata[0]),
        .s0_wstrb(wstrb[0]), .s0_bvalid(bvalid[0]), .s0_bready(bready[0]),
        .s0_bresp(bresp[0]), .s0_arvalid(arvalid[0]), .s0_arready(arready[0]),
        .s0_araddr(araddr[0]), .s0_rvalid(rvalid[0]), .s0_rready(rready[0]),
        .s0_rdata(rdata[0]), .s0_rresp(rresp[0]),
        .s1_awvalid(awvalid[1]), .s1_awready(awready[1]), .s1_awaddr(awaddr[1]),
        .s1_wvalid(wvalid[1]), .s1_wready(wready[1]), .s1_wdata(wdata[1]),
        .s1_wstrb(wstrb[1]), .s1_bvalid(bvalid[1]), .s1_bready(bready[1]),
        .s1_bresp(bresp[1]), .s1_arvalid(arvalid[1]), .s1_arready(arready[1]),
        .s1_araddr(araddr[1]), .s1_rvalid(rvalid[1]), .s1_rready(rready[1]),
        .s1_rdata(rdata[1]), .s1_rresp(rresp[1])
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    task automatic stop_with_error(input string what);
        err_count++;
        $display("ERROR at %0t: %s", $time, what);
        $display("*** FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            stop_with_error("value mismatch");
        end
    endtask

    // idle ports have all readies up and no response pending
    task automatic check_idle_outputs();
        for (int p = 0; p < 2; p++) begin
            assert (awready[p] && wready[p] && arready[p])
                else stop_with_error($sformatf("port %0d readies not high after reset", p));
            assert (!bvalid[p] && !rvalid[p])
                else stop_with_error($sformatf("port %0d response valid after reset", p));
        end
    endtask

    task automatic apply_to_ref(input logic [ABW-1:0] addr, input logic [31:0] data,
                                input logic [BW-1:0] strb);
        for (int b = 0; b < BW; b++) begin
            if (strb[b]) begin
                ref_mem[addr[ABW-1 -: `SPRAM_AW]][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    // B channel with a random stall on bready
    task automatic take_bresp(input int p);
        int cnt;
        int hold;
        cnt  = 0;
        hold = $random(seed) & 3;
        do begin
            @(negedge clk);
            cnt++;
            assert (cnt <= TMO)
                else stop_with_error($sformatf("port %0d never raised bvalid", p));
        end while (!bvalid[p]);
        for (int k = 0; k < hold; k++) begin
            @(negedge clk);
            assert (bvalid[p]) else stop_with_error("bvalid dropped while bready was low");
        end
        @(posedge clk);
        #1;
        bready[p] = 1'b1;
        @(negedge clk);
        assert (bvalid[p]) else stop_with_error("bvalid dropped before the handshake");
        compare_word($sformatf("s%0d_bresp", p), 32'(bresp[p]), 32'(AXI_OKAY));
        @(posedge clk);  // handshake edge
        #1;
        bready[p] = 1'b0;
    endtask

    // R channel data must hold while rready is low
    task automatic take_rdata(input int p, input logic [31:0] exp);
        int          cnt;
        int          hold;
        logic [31:0] first;
        cnt  = 0;
        hold = $random(seed) & 3;
        do begin
            @(negedge clk);
            cnt++;
            assert (cnt <= TMO)
                else stop_with_error($sformatf("port %0d never raised rvalid", p));
        end while (!rvalid[p]);
        first = rdata[p];
        for (int k = 0; k < hold; k++) begin
            @(negedge clk);
            assert (rvalid[p]) else stop_with_error("rvalid dropped while rready was low");
            compare_word($sformatf("s%0d_rdata (stalled)", p), rdata[p], first);
        end
        @(posedge clk);
        #1;
        rready[p] = 1'b1;
        @(negedge clk);
        assert (rvalid[p]) else stop_with_error("rvalid dropped before the handshake");
        compare_word($sformatf("s%0d_rdata", p), rdata[p], exp);
        compare_word($sformatf("s%0d_rresp", p), 32'(rresp[p]), 32'(AXI_OKAY));
        @(posedge clk);
        #1;
        rready[p] = 1'b0;
    endtask

    task automatic axi_write(input int p, input logic [ABW-1:0] addr,
                             input logic [31:0] data, input logic [BW-1:0] strb);
        int   cnt;
        logic aw_open;
        logic w_open;
        logic aw_fire;
        logic w_fire;
        awaddr[p]  = addr;
        wdata[p]   = data;
        wstrb[p]   = strb;
        awvalid[p] = 1'b1;
        wvalid[p]  = 1'b1;
        aw_open    = 1'b1;
        w_open     = 1'b1;
        cnt        = 0;
        while (aw_open || w_open) begin
            @(negedge clk);
            aw_fire = awvalid[p] && awready[p];  // sampled mid-cycle
            w_fire  = wvalid[p] && wready[p];
            @(posedge clk);
            #1;
            if (aw_fire) begin
                awvalid[p] = 1'b0;
                aw_open    = 1'b0;
            end
            if (w_fire) begin
                wvalid[p] = 1'b0;
                w_open    = 1'b0;
            end
            cnt++;
            assert (cnt <= TMO)
                else stop_with_error($sformatf("port %0d AW/W never accepted", p));
        end
        apply_to_ref(addr, data, strb);
        take_bresp(p);
    endtask

    task automatic axi_read(input int p, input logic [ABW-1:0] addr,
                            input logic [31:0] exp);
        int   cnt;
        logic fire;
        araddr[p]  = addr;
        arvalid[p] = 1'b1;
        fire       = 1'b0;
        cnt        = 0;
        while (!fire) begin
            @(negedge clk);
            fire = arready[p];
            @(posedge clk);
            #1;
            cnt++;
            assert (cnt <= TMO)
                else stop_with_error($sformatf("port %0d AR never accepted", p));
        end
        arvalid[p] = 1'b0;
        take_rdata(p, exp);
    endtask

    task automatic run_stim_line(input int i);
        int             p;
        int             op;
        logic [ABW-1:0] addr;
        logic [31:0]    exp;
        p    = int'(stim[i*NCOL+1]);
        op   = int'(stim[i*NCOL+2]);
        addr = stim[i*NCOL+3][ABW-1:0];
        exp  = stim[i*NCOL+6];
        if (op == 1) begin
            axi_write(p, addr, stim[i*NCOL+4], stim[i*NCOL+5][BW-1:0]);
        end else begin
            // file column must agree with the reference array
            compare_word("expect column vs reference", exp,
                         ref_mem[addr[ABW-1 -: `SPRAM_AW]]);
            axi_read(p, addr, ref_mem[addr[ABW-1 -: `SPRAM_AW]]);
        end
    endtask

    initial begin
        int i;
        seed      = 96500;
        err_count = 0;
        rst_n     = 1'b0;
        awvalid   = '0;
        wvalid    = '0;
        bready    = '0;
        arvalid   = '0;
        rready    = '0;
        for (int k = 0; k < 2; k++) begin
            awaddr[k] = '0;
            araddr[k] = '0;
            wdata[k]  = '0;
            wstrb[k]  = '0;
        end
        $readmemh("verification/spram_input.txt", stim);
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs();
        @(posedge clk);
        #1;
        i = 0;
        while (i < MAXL && stim[i*NCOL+2] != 0) begin  // op 0 ends the list
            if (stim[i*NCOL] != 0 && i + 1 < MAXL) begin
                fork
                    run_stim_line(i);
                    run_stim_line(i + 1);
                join
                i = i + 2;
            end else begin
                run_stim_line(i);
                i = i + 1;
            end
        end
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+include
source/spram_pkg.sv
source/sram_macro_model.sv
source/spram_tiled.sv
source/mem_arbiter.sv
source/axil_mem_port.sv
source/spram_subsystem_top.sv
verification/spram_assertions.sv
verification/tb_spram_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Builds the shared SRAM testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_spram_subsystem \
    -f files.f

./obj_dir/Vtb_spram_subsystem | tee sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// File: verification/spram_input.txt
// par port op addr data strb expect, all hex; addr is a byte address
// op 1 write, 2 read, 0 end; par 1 runs the line together with the next one
0 0 1 010 DEADBEEF F 00000000
0 0 2 010 00000000 0 DEADBEEF
0 1 1 020 CAFEF00D F 00000000
0 0 2 020 00000000 0 CAFEF00D
0 0 1 010 000000A5 1 00000000
0 1 1 010 77660000 C 00000000
0 1 2 010 00000000 0 7766BEA5
0 0 1 410 11111111 F 00000000
0 1 1 810 22222222 F 00000000
0 0 1 C10 33333333 F 00000000
0 1 2 410 00000000 0 11111111
0 0 2 C10 00000000 0 33333333
0 1 2 010 00000000 0 7766BEA5
1 0 2 810 00000000 0 22222222
0 1 1 100 5A5A5A5A F 00000000
1 0 1 200 0BADC0DE F 00000000
0 1 2 C10 00000000 0 33333333
1 0 2 100 00000000 0 5A5A5A5A
0 1 2 200 00000000 0 0BADC0DE
1 0 1 300 01234567 F 00000000
0 1 1 304 89ABCDEF F 00000000
1 0 2 304 00000000 0 89ABCDEF
0 1 2 300 00000000 0 01234567
0 0 0 000 00000000 0 00000000
